// ==== source/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`define MEM_ADDR_W   32   // byte address
`define MEM_WORD_W   32   // processor word
`define MEM_MASK_W   4    // one enable per byte of a word
`define MEM_LINE_W   256  // cache line
`define MEM_BEAT_W   64   // bmem burst beat
`define MEM_BEATS    4    // beats per line
`define MEM_OFFSET_W 5    // byte offset inside a line
`define MEM_INDEX_W  3    // 8 sets
`define MEM_TAG_W    24   // what is left of the address

`endif

// ==== source/mem_pkg.sv ====
`default_nettype none
`include "mem_defines.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0]  addr_t;   // byte address
    typedef logic [`MEM_WORD_W-1:0]  word_t;
    typedef logic [`MEM_MASK_W-1:0]  mask_t;   // byte enables
    typedef logic [`MEM_LINE_W-1:0]  line_t;
    typedef logic [`MEM_BEAT_W-1:0]  beat_t;   // one bmem beat
    typedef logic [`MEM_TAG_W-1:0]   tag_t;
    typedef logic [`MEM_INDEX_W-1:0] index_t;

    typedef enum logic [1:0] {
        cache_idle,
        cache_lookup,       // registered tag compare
        cache_writeback,    // dirty victim out
        cache_fill          // new line in
    } cache_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_grant_i,
        arb_grant_d
    } arb_state_e;

    typedef enum logic [2:0] {
        adapt_idle,
        adapt_read_wait,    // read held until first beat
        adapt_read_beats,
        adapt_write_beats,
        adapt_write_wait    // waiting on the write ack
    } adapt_state_e;

endpackage : mem_pkg

`default_nettype wire

// ==== source/icache.sv ====
`default_nettype none
`include "mem_defines.svh"

module icache (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t address_i,       // from fetch
    input  logic           read_i,
    output mem_pkg::word_t rdata_o,         // valid with resp_o
    output logic           resp_o,
    output mem_pkg::addr_t pmem_address_o,  // to arbiter
    output logic           pmem_read_o,
    input  mem_pkg::line_t pmem_rdata_i,    // from arbiter
    input  logic           pmem_resp_i
);

    localparam int SETS   = 1 << `MEM_INDEX_W;
    localparam int WSEL_W = `MEM_OFFSET_W - 2;   // word inside the line

    mem_pkg::cache_state_e state_q;
    mem_pkg::line_t        lines_q [SETS];
    mem_pkg::tag_t         tags_q  [SETS];
    logic [SETS-1:0]       valid_q;
    logic                  hit_q;              // tag compare from idle

    mem_pkg::tag_t         tag;
    mem_pkg::index_t       idx;
    logic [WSEL_W-1:0]     wsel;

    assign tag  = address_i[`MEM_ADDR_W-1 -: `MEM_TAG_W];
    assign idx  = address_i[`MEM_OFFSET_W +: `MEM_INDEX_W];
    assign wsel = address_i[2 +: WSEL_W];

    assign rdata_o        = lines_q[idx][wsel * `MEM_WORD_W +: `MEM_WORD_W];
    assign resp_o         = (state_q == mem_pkg::cache_lookup) && hit_q;
    assign pmem_read_o    = (state_q == mem_pkg::cache_fill);
    assign pmem_address_o = {tag, idx, {`MEM_OFFSET_W{1'b0}}};   // line aligned

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_pkg::cache_idle;
            valid_q <= '0;                     // all lines invalid
            hit_q   <= 1'b0;
        end else begin
            case (state_q)
                mem_pkg::cache_idle: begin
                    if (read_i) begin
                        hit_q   <= valid_q[idx] && (tags_q[idx] == tag);
                        state_q <= mem_pkg::cache_lookup;
                    end
                end
                mem_pkg::cache_lookup: begin
                    state_q <= hit_q ? mem_pkg::cache_idle : mem_pkg::cache_fill;
                end
                mem_pkg::cache_fill: begin
                    if (pmem_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        hit_q        <= 1'b1;  // answer from the new line
                        state_q      <= mem_pkg::cache_lookup;
                    end
                end
                default: state_q <= mem_pkg::cache_idle;
            endcase
        end
    end

    // line and tag written on fill only
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::cache_fill && pmem_resp_i) begin
            lines_q[idx] <= pmem_rdata_i;
            tags_q[idx]  <= tag;
        end
    end

    // requester must hold read until the answer
    resp_needs_read: assert property (@(posedge clk) disable iff (reset_i)
        resp_o |-> read_i)
        else $error("icache resp while read_i is low");

endmodule : icache

`default_nettype wire

// ==== source/dcache.sv ====
`default_nettype none
`include "mem_defines.svh"

module dcache (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t address_i,       // from load/store unit
    input  logic           read_i,
    input  logic           write_i,
    input  mem_pkg::mask_t wmask_i,
    input  mem_pkg::word_t wdata_i,
    output mem_pkg::word_t rdata_o,
    output logic           resp_o,
    output mem_pkg::addr_t pmem_address_o,  // to arbiter
    output logic           pmem_read_o,
    output logic           pmem_write_o,
    output mem_pkg::line_t pmem_wdata_o,
    input  mem_pkg::line_t pmem_rdata_i,    // from arbiter
    input  logic           pmem_resp_i
);

    localparam int SETS       = 1 << `MEM_INDEX_W;
    localparam int WSEL_W     = `MEM_OFFSET_W - 2;
    localparam int LINE_BYTES = `MEM_LINE_W / 8;

    mem_pkg::cache_state_e  state_q;
    mem_pkg::line_t         lines_q [SETS];
    mem_pkg::tag_t          tags_q  [SETS];
    logic [SETS-1:0]        valid_q;
    logic [SETS-1:0]        dirty_q;
    logic                   hit_q;

    mem_pkg::tag_t          tag;
    mem_pkg::index_t        idx;
    logic [WSEL_W-1:0]      wsel;
    logic [LINE_BYTES-1:0]  byte_en;         // word mask at line position
    mem_pkg::line_t         wdata_line;      // word data at line position
    logic                   victim_dirty;

    assign tag  = address_i[`MEM_ADDR_W-1 -: `MEM_TAG_W];
    assign idx  = address_i[`MEM_OFFSET_W +: `MEM_INDEX_W];
    assign wsel = address_i[2 +: WSEL_W];

    assign byte_en      = LINE_BYTES'(wmask_i) << (wsel * `MEM_MASK_W);
    assign wdata_line   = mem_pkg::line_t'(wdata_i) << (wsel * `MEM_WORD_W);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];

    assign rdata_o      = lines_q[idx][wsel * `MEM_WORD_W +: `MEM_WORD_W];
    assign resp_o       = (state_q == mem_pkg::cache_lookup) && hit_q;
    assign pmem_read_o  = (state_q == mem_pkg::cache_fill);
    assign pmem_write_o = (state_q == mem_pkg::cache_writeback);
    assign pmem_wdata_o = lines_q[idx];      // victim line

    // victim goes back to its own tag
    assign pmem_address_o = pmem_write_o ? {tags_q[idx], idx, {`MEM_OFFSET_W{1'b0}}}
                                         : {tag, idx, {`MEM_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_pkg::cache_idle;
            valid_q <= '0;
            dirty_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            case (state_q)
                mem_pkg::cache_idle: begin
                    if (read_i || write_i) begin
                        hit_q   <= valid_q[idx] && (tags_q[idx] == tag);
                        state_q <= mem_pkg::cache_lookup;
                    end
                end
                mem_pkg::cache_lookup: begin
                    if (hit_q) begin
                        state_q <= mem_pkg::cache_idle;
                        if (write_i) begin
                            dirty_q[idx] <= 1'b1;       // merged below
                        end
                    end else if (victim_dirty) begin
                        state_q <= mem_pkg::cache_writeback;
                    end else begin
                        state_q <= mem_pkg::cache_fill;
                    end
                end
                mem_pkg::cache_writeback: begin
                    if (pmem_resp_i) begin
                        state_q <= mem_pkg::cache_fill;
                    end
                end
                mem_pkg::cache_fill: begin
                    if (pmem_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;           // clean copy of memory
                        hit_q        <= 1'b1;           // retry lookup, now a hit
                        state_q      <= mem_pkg::cache_lookup;
                    end
                end
                default: state_q <= mem_pkg::cache_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::cache_fill && pmem_resp_i) begin
            lines_q[idx] <= pmem_rdata_i;
            tags_q[idx]  <= tag;
        end else if (resp_o && write_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (byte_en[b]) begin
                    lines_q[idx][b*8 +: 8] <= wdata_line[b*8 +: 8];   // enabled bytes only
                end
            end
        end
    end

    no_read_and_write: assert property (@(posedge clk) disable iff (reset_i)
        !(read_i && write_i))
        else $error("dcache read_i and write_i both high");

    no_pmem_read_and_write: assert property (@(posedge clk) disable iff (reset_i)
        !(pmem_read_o && pmem_write_o))
        else $error("dcache pmem read and write both high");

endmodule : dcache

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t i_address_i,     // from icache
    input  logic           i_read_i,
    output mem_pkg::line_t i_rdata_o,
    output logic           i_resp_o,
    input  mem_pkg::addr_t d_address_i,     // from dcache
    input  logic           d_read_i,
    input  logic           d_write_i,
    input  mem_pkg::line_t d_wdata_i,
    output mem_pkg::line_t d_rdata_o,
    output logic           d_resp_o,
    output mem_pkg::addr_t pmem_address_o,  // to cacheline adaptor
    output logic           pmem_read_o,
    output logic           pmem_write_o,
    output mem_pkg::line_t pmem_wdata_o,
    input  mem_pkg::line_t pmem_rdata_i,
    input  logic           pmem_resp_i
);

    mem_pkg::arb_state_e state_q;
    logic                grant_i;
    logic                grant_d;

    assign grant_i = (state_q == mem_pkg::arb_grant_i);
    assign grant_d = (state_q == mem_pkg::arb_grant_d);

    assign pmem_address_o = grant_d ? d_address_i : i_address_i;
    assign pmem_read_o    = (grant_d && d_read_i) || (grant_i && i_read_i);
    assign pmem_write_o   = grant_d && d_write_i;    // icache never writes
    assign pmem_wdata_o   = d_wdata_i;

    assign i_rdata_o = pmem_rdata_i;                 // shared, qualified by resp
    assign d_rdata_o = pmem_rdata_i;
    assign i_resp_o  = grant_i && pmem_resp_i;
    assign d_resp_o  = grant_d && pmem_resp_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_pkg::arb_idle;
        end else begin
            case (state_q)
                mem_pkg::arb_idle: begin
                    if (d_read_i || d_write_i) begin
                        state_q <= mem_pkg::arb_grant_d;   // data side wins a tie
                    end else if (i_read_i) begin
                        state_q <= mem_pkg::arb_grant_i;
                    end
                end
                default: begin
                    if (pmem_resp_i) begin
                        state_q <= mem_pkg::arb_idle;      // one transfer per grant
                    end
                end
            endcase
        end
    end

    one_resp_at_a_time: assert property (@(posedge clk) disable iff (reset_i)
        !(i_resp_o && d_resp_o))
        else $error("arbiter answered both caches at once");

endmodule : mem_arbiter

`default_nettype wire

// ==== source/cacheline_adaptor.sv ====
`default_nettype none
`include "mem_defines.svh"

module cacheline_adaptor (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t address_i,   // from arbiter
    input  mem_pkg::line_t line_i,
    input  logic           read_i,
    input  logic           write_i,
    output mem_pkg::line_t line_o,      // to arbiter
    output logic           resp_o,
    output mem_pkg::addr_t address_o,   // to bmem
    output logic           read_o,
    output logic           write_o,
    output mem_pkg::beat_t burst_o,
    input  mem_pkg::beat_t burst_i,     // from bmem
    input  logic           bmem_resp_i
);

    localparam int CNT_W = $clog2(`MEM_BEATS);

    mem_pkg::adapt_state_e state_q;
    logic [CNT_W-1:0]      beat_q;      // beat in flight
    logic                  resp_q;
    mem_pkg::addr_t        addr_q;
    mem_pkg::line_t        line_q;      // shift register for both directions
    logic                  accept;
    logic                  last_beat;
    logic                  rd_beat;

    assign accept    = (state_q == mem_pkg::adapt_idle) && !resp_q && (read_i || write_i);
    assign last_beat = (beat_q == CNT_W'(`MEM_BEATS - 1));
    assign rd_beat   = bmem_resp_i && (state_q == mem_pkg::adapt_read_wait ||
                                       state_q == mem_pkg::adapt_read_beats);

    assign line_o    = line_q;
    assign resp_o    = resp_q;
    assign address_o = addr_q;
    assign read_o    = (state_q == mem_pkg::adapt_read_wait);
    assign write_o   = (state_q == mem_pkg::adapt_write_beats);
    assign burst_o   = line_q[beat_q * `MEM_BEAT_W +: `MEM_BEAT_W];   // lowest beat first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_pkg::adapt_idle;
            beat_q  <= '0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= 1'b0;                  // one cycle pulse
            case (state_q)
                mem_pkg::adapt_idle: begin
                    beat_q <= '0;
                    if (accept) begin
                        state_q <= read_i ? mem_pkg::adapt_read_wait
                                          : mem_pkg::adapt_write_beats;
                    end
                end
                mem_pkg::adapt_read_wait: begin
                    if (bmem_resp_i) begin
                        beat_q  <= beat_q + 1'b1;
                        state_q <= mem_pkg::adapt_read_beats;
                    end
                end
                mem_pkg::adapt_read_beats: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            resp_q  <= 1'b1;
                            state_q <= mem_pkg::adapt_idle;
                        end
                    end
                end
                mem_pkg::adapt_write_beats: begin
                    beat_q <= beat_q + 1'b1;  // back to back beats
                    if (last_beat) begin
                        state_q <= mem_pkg::adapt_write_wait;
                    end
                end
                mem_pkg::adapt_write_wait: begin
                    if (bmem_resp_i) begin
                        resp_q  <= 1'b1;
                        state_q <= mem_pkg::adapt_idle;
                    end
                end
                default: state_q <= mem_pkg::adapt_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= address_i;
            line_q <= line_i;
        end else if (rd_beat) begin
            line_q[beat_q * `MEM_BEAT_W +: `MEM_BEAT_W] <= burst_i;
        end
    end

    no_bmem_read_and_write: assert property (@(posedge clk) disable iff (reset_i)
        !(read_o && write_o))
        else $error("adaptor drives bmem read and write together");

endmodule : cacheline_adaptor

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t imem_address_i,
    input  logic           imem_read_i,
    output mem_pkg::word_t imem_rdata_o,
    output logic           imem_resp_o,
    input  mem_pkg::addr_t dmem_address_i,
    input  logic           dmem_read_i,
    input  logic           dmem_write_i,
    input  mem_pkg::mask_t dmem_wmask_i,
    input  mem_pkg::word_t dmem_wdata_i,
    output mem_pkg::word_t dmem_rdata_o,
    output logic           dmem_resp_o,
    output mem_pkg::addr_t bmem_address_o,
    output logic           bmem_read_o,
    output logic           bmem_write_o,
    output mem_pkg::beat_t bmem_wdata_o,
    input  mem_pkg::beat_t bmem_rdata_i,
    input  logic           bmem_resp_i
);

    mem_pkg::addr_t ipmem_address;   // icache -> arbiter
    logic           ipmem_read;
    mem_pkg::line_t ipmem_rdata;     // icache <- arbiter
    logic           ipmem_resp;
    mem_pkg::addr_t dpmem_address;   // dcache -> arbiter
    logic           dpmem_read;
    logic           dpmem_write;
    mem_pkg::line_t dpmem_wdata;
    mem_pkg::line_t dpmem_rdata;     // dcache <- arbiter
    logic           dpmem_resp;
    mem_pkg::addr_t pmem_address;    // arbiter -> adaptor
    logic           pmem_read;
    logic           pmem_write;
    mem_pkg::line_t pmem_wdata;
    mem_pkg::line_t pmem_rdata;      // arbiter <- adaptor
    logic           pmem_resp;

    icache imem_cache (.clk, .reset_i,
        .address_i      (imem_address_i),
        .read_i         (imem_read_i),
        .rdata_o        (imem_rdata_o),
        .resp_o         (imem_resp_o),
        .pmem_address_o (ipmem_address),
        .pmem_read_o    (ipmem_read),
        .pmem_rdata_i   (ipmem_rdata),
        .pmem_resp_i    (ipmem_resp)
    );

    dcache dmem_cache (.clk, .reset_i,
        .address_i      (dmem_address_i),
        .read_i         (dmem_read_i),
        .write_i        (dmem_write_i),
        .wmask_i        (dmem_wmask_i),
        .wdata_i        (dmem_wdata_i),
        .rdata_o        (dmem_rdata_o),
        .resp_o         (dmem_resp_o),
        .pmem_address_o (dpmem_address),
        .pmem_read_o    (dpmem_read),
        .pmem_write_o   (dpmem_write),
        .pmem_wdata_o   (dpmem_wdata),
        .pmem_rdata_i   (dpmem_rdata),
        .pmem_resp_i    (dpmem_resp)
    );

    mem_arbiter arbiter (.clk, .reset_i,
        .i_address_i    (ipmem_address),
        .i_read_i       (ipmem_read),
        .i_rdata_o      (ipmem_rdata),
        .i_resp_o       (ipmem_resp),
        .d_address_i    (dpmem_address),
        .d_read_i       (dpmem_read),
        .d_write_i      (dpmem_write),
        .d_wdata_i      (dpmem_wdata),
        .d_rdata_o      (dpmem_rdata),
        .d_resp_o       (dpmem_resp),
        .pmem_address_o (pmem_address),
        .pmem_read_o    (pmem_read),
        .pmem_write_o   (pmem_write),
        .pmem_wdata_o   (pmem_wdata),
        .pmem_rdata_i   (pmem_rdata),
        .pmem_resp_i    (pmem_resp)
    );

    cacheline_adaptor cacheline_adaptor (.clk, .reset_i,
        .address_i      (pmem_address),
        .line_i         (pmem_wdata),
        .read_i         (pmem_read),
        .write_i        (pmem_write),
        .line_o         (pmem_rdata),
        .resp_o         (pmem_resp),
        .address_o      (bmem_address_o),   // to burst memory
        .read_o         (bmem_read_o),
        .write_o        (bmem_write_o),
        .burst_o        (bmem_wdata_o),
        .burst_i        (bmem_rdata_i),     // from burst memory
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mem_subsystem

`default_nettype wire

// ==== test/bmem_model.sv ====
`default_nettype none

module bmem_model (
    input  logic           clk,
    input  logic           reset_i,
    input  mem_pkg::addr_t address_i,
    input  logic           read_i,
    input  logic           write_i,
    input  mem_pkg::beat_t wdata_i,
    output mem_pkg::beat_t rdata_o,
    output logic           resp_o,
    output int             read_count_o,    // bursts read so far
    output int             write_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int READ_DELAY = 3;          // cycles before the first beat

    mem_pkg::word_t words [mem_pkg::addr_t];   // only written words stored
    int             delay_q;
    int             rbeat_q;
    int             wbeat_q;
    logic           reading_q;

    // untouched words hold the inverse of their byte address
    function automatic mem_pkg::word_t fetch_word(input mem_pkg::addr_t a);
        return words.exists(a) ? words[a] : ~a;
    endfunction

    always @(posedge clk) begin
        resp_o <= 1'b0;
        if (reset_i) begin
            reading_q     <= 1'b0;
            delay_q       <= 0;
            rbeat_q       <= 0;
            wbeat_q       <= 0;
            read_count_o  <= 0;
            write_count_o <= 0;
            rdata_o       <= '0;
        end else if (reading_q) begin
            if (delay_q > 0) begin
                delay_q <= delay_q - 1;
            end else begin
                rdata_o <= {fetch_word(address_i + rbeat_q * 8 + 4),
                            fetch_word(address_i + rbeat_q * 8)};
                resp_o  <= 1'b1;            // beats back to back
                rbeat_q <= rbeat_q + 1;
                if (rbeat_q == 3) begin
                    reading_q <= 1'b0;
                end
            end
        end else if (write_i) begin
            words[address_i + wbeat_q * 8]     = wdata_i[31:0];
            words[address_i + wbeat_q * 8 + 4] = wdata_i[63:32];
            if (wbeat_q == 3) begin
                wbeat_q       <= 0;
                resp_o        <= 1'b1;      // ack after the last beat
                write_count_o <= write_count_o + 1;
            end else begin
                wbeat_q <= wbeat_q + 1;
            end
        end else if (read_i) begin
            reading_q    <= 1'b1;
            delay_q      <= READ_DELAY - 1;
            rbeat_q      <= 0;
            read_count_o <= read_count_o + 1;
        end
    end

endmodule : bmem_model

`default_nettype wire

// ==== test/mem_subsystem_tb.sv ====
`default_nettype none

module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 300;           // cycles per wait
    localparam int RANDOM_OPS = 200;

    logic           clk = 1'b0;
    logic           reset_i;
    mem_pkg::addr_t imem_address_i;
    logic           imem_read_i;
    mem_pkg::word_t imem_rdata_o;
    logic           imem_resp_o;
    mem_pkg::addr_t dmem_address_i;
    logic           dmem_read_i;
    logic           dmem_write_i;
    mem_pkg::mask_t dmem_wmask_i;
    mem_pkg::word_t dmem_wdata_i;
    mem_pkg::word_t dmem_rdata_o;
    logic           dmem_resp_o;
    mem_pkg::addr_t bmem_address_o;
    logic           bmem_read_o;
    logic           bmem_write_o;
    mem_pkg::beat_t bmem_wdata_o;
    mem_pkg::beat_t bmem_rdata_i;
    logic           bmem_resp_i;
    int             read_count;
    int             write_count;

    mem_pkg::word_t shadow [mem_pkg::addr_t];   // words written by the tests
    int             errors = 0;
    int             checks = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    integer         seed = 68;

    always #5 clk = ~clk;

    mem_subsystem dut (.*);

    bmem_model memory (
        .clk, .reset_i,
        .address_i     (bmem_address_o),
        .read_i        (bmem_read_o),
        .write_i       (bmem_write_o),
        .wdata_i       (bmem_wdata_o),
        .rdata_o       (bmem_rdata_i),
        .resp_o        (bmem_resp_i),
        .read_count_o  (read_count),
        .write_count_o (write_count)
    );

    function automatic mem_pkg::word_t expected_word(input mem_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : ~a;
    endfunction

    // byte merge of a masked store into the reference copy
    task automatic shadow_write(input mem_pkg::addr_t a, input mem_pkg::mask_t m,
                                input mem_pkg::word_t d);
        mem_pkg::word_t w;
        w = expected_word(a);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) w[b*8 +: 8] = d[b*8 +: 8];
        end
        shadow[a] = w;
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp,
                            input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_timeout(input string name);
        $display("%s: no response from the DUT within %0d cycles", name, TIMEOUT);
        errors++;
    endtask

    // one data request held until resp and sampled at the falling edge
    task automatic dmem_access(input string name, input mem_pkg::addr_t a,
                               input logic wr, input mem_pkg::mask_t m,
                               input mem_pkg::word_t d, output mem_pkg::word_t rdata);
        bit got;
        got   = 0;
        rdata = '0;
        dmem_address_i = a;
        dmem_read_i    = !wr;
        dmem_write_i   = wr;
        dmem_wmask_i   = m;
        dmem_wdata_i   = d;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (dmem_resp_o) begin
                rdata = dmem_rdata_o;
                got   = 1;
                break;
            end
        end
        if (!got) report_timeout(name);
        @(posedge clk);
        #1;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        if (wr) shadow_write(a, m, d);
    endtask

    task automatic imem_fetch(input string name, input mem_pkg::addr_t a,
                              output mem_pkg::word_t rdata, output int cycles);
        bit got;
        got    = 0;
        rdata  = '0;
        cycles = 0;
        imem_address_i = a;
        imem_read_i    = 1'b1;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            cycles = n + 1;
            if (imem_resp_o) begin
                rdata = imem_rdata_o;
                got   = 1;
                break;
            end
        end
        if (!got) report_timeout(name);
        @(posedge clk);
        #1;
        imem_read_i = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %s %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    task automatic reset_outputs_low();
        int e0;
        e0 = errors;
        reset_i = 1'b1;
        repeat (16) begin
            @(negedge clk);
            check_eq("reset", 0, {imem_resp_o, dmem_resp_o, bmem_read_o, bmem_write_o});
        end
        @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_eq("reset", 0, {imem_resp_o, dmem_resp_o, bmem_read_o, bmem_write_o});
        end
        @(posedge clk);
        #1;
        finish_test("reset", e0);
    endtask

    task automatic fetch_one_line();
        int             e0;
        int             reads0;
        int             cycles;
        mem_pkg::word_t got;
        mem_pkg::addr_t a;
        e0     = errors;
        reads0 = read_count;
        for (int w = 0; w < 8; w++) begin
            a = 32'h0000_0400 + w * 4;
            imem_fetch("fetch", a, got, cycles);
            check_eq("fetch", ~a, got);
            if (w != 0) check_eq("fetch hit latency", 2, cycles);   // resp one cycle on
        end
        check_eq("fetch bmem reads", 1, read_count - reads0);
        finish_test("fetch", e0);
    endtask

    task automatic masked_write_merge();
        int             e0;
        mem_pkg::word_t got;
        mem_pkg::word_t d;
        e0 = errors;
        d  = $random(seed);
        dmem_access("masked write", 32'h0000_0504, 1'b0, 4'h0, '0, got);
        dmem_access("masked write", 32'h0000_0504, 1'b1, 4'b0101, d, got);
        dmem_access("masked write", 32'h0000_0504, 1'b0, 4'h0, '0, got);
        check_eq("masked write", {~32'h0000_0504 & 32'hff00_ff00} | (d & 32'h00ff_00ff), got);
        finish_test("masked write", e0);
    endtask

    task automatic dirty_eviction();
        int             e0;
        int             writes0;
        mem_pkg::word_t got;
        e0      = errors;
        writes0 = write_count;
        dmem_access("eviction", 32'h0000_0628, 1'b1, 4'hf, 32'hcafe_f00d, got);
        dmem_access("eviction", 32'h0000_0728, 1'b0, 4'h0, '0, got);   // same set
        check_eq("eviction", ~32'h0000_0728, got);
        dmem_access("eviction", 32'h0000_0628, 1'b0, 4'h0, '0, got);
        check_eq("eviction", 32'hcafe_f00d, got);
        check_eq("eviction writebacks", 1, write_count - writes0);
        finish_test("eviction", e0);
    endtask

    task automatic concurrent_misses();
        int             e0;
        bit             i_done;
        bit             d_done;
        mem_pkg::word_t i_data;
        mem_pkg::word_t d_data;
        e0     = errors;
        i_done = 0;
        d_done = 0;
        i_data = '0;
        d_data = '0;
        imem_address_i = 32'h0000_2004;
        dmem_address_i = 32'h0000_3048;
        imem_read_i    = 1'b1;
        dmem_read_i    = 1'b1;   // same cycle
        for (int n = 0; n < TIMEOUT && !(i_done && d_done); n++) begin
            @(negedge clk);
            if (imem_resp_o && !i_done) begin
                i_data = imem_rdata_o;
                i_done = 1;
            end
            if (dmem_resp_o && !d_done) begin
                d_data = dmem_rdata_o;
                d_done = 1;
            end
            @(posedge clk);
            #1;
            if (i_done) imem_read_i = 1'b0;
            if (d_done) dmem_read_i = 1'b0;
        end
        if (!(i_done && d_done)) report_timeout("concurrent");
        imem_read_i = 1'b0;
        dmem_read_i = 1'b0;
        check_eq("concurrent ifetch", ~32'h0000_2004, i_data);
        check_eq("concurrent load", expected_word(32'h0000_3048), d_data);
        finish_test("concurrent", e0);
    endtask

    task automatic random_traffic();
        int             e0;
        mem_pkg::addr_t a;
        mem_pkg::word_t d;
        mem_pkg::word_t got;
        logic           wr;
        e0 = errors;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            // 4 tags by 8 sets by 8 words above the other tests
            a  = 32'h0001_0000 | (($random(seed) & 32'h3ff) & ~32'h3);
            d  = $random(seed);
            wr = $random(seed) & 1;
            dmem_access("random", a, wr, mem_pkg::mask_t'($random(seed)), d, got);
            if (!wr) check_eq("random", expected_word(a), got);
        end
        finish_test("random", e0);
    endtask

    initial begin
        reset_i        = 1'b1;
        imem_address_i = '0;
        imem_read_i    = 1'b0;
        dmem_address_i = '0;
        dmem_read_i    = 1'b0;
        dmem_write_i   = 1'b0;
        dmem_wmask_i   = '0;
        dmem_wdata_i   = '0;
        @(posedge clk);
        #1;
        reset_outputs_low();
        fetch_one_line();
        masked_write_merge();
        dirty_eviction();
        concurrent_misses();
        random_traffic();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/mem_pkg.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/cacheline_adaptor.sv
source/mem_subsystem.sv
test/bmem_model.sv
test/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module mem_subsystem_tb -o mem_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/mem_subsystem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" "$LOG"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
